// File: all.f
common/game_pkg.sv
common/rotate_if.sv
rotate/rotate_xy.sv
src/rotate_arbiter.sv
src/car_dynamics.sv
src/frame_sequencer.sv
src/game_control_top.sv
sim/game_control_properties.sv
sim/tb_game_control.sv

// File: run.sh
#!/bin/sh
# compile and run the game control testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_game_control -f all.f \
    && ./obj_dir/Vtb_game_control +verilator+error+limit+10 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF '*** TEST PASSED ***' sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: sim/tb_game_control.sv
`timescale 1ns/10ps
`default_nettype none

module tb_game_control import game_pkg::*; ();

    localparam int RESET_CYCLES  = 8;
    localparam int LATE_FRAMES   = 2;     // ack held long by a slow requester
    localparam int ACCEL_FRAMES  = 20;
    localparam int DECAY_FRAMES  = 15;
    localparam int TURN_FRAMES   = 200;
    localparam int CRUISE_FRAMES = 250;   // long straight runs across the map edges
    localparam int RANDOM_FRAMES = 300;
    localparam int NUM_FRAMES    = LATE_FRAMES + ACCEL_FRAMES + DECAY_FRAMES + TURN_FRAMES
                                 + CRUISE_FRAMES + RANDOM_FRAMES;
    localparam int CYCLE_LIMIT   = 40 * NUM_FRAMES + RESET_CYCLES;

    localparam int CAR1_X0 = -750;
    localparam int CAR1_Y0 = 300;
    localparam int CAR2_X0 = 750;
    localparam int CAR2_Y0 = -300;
    localparam int X_LO    = -750;
    localparam int X_HI    = 750;
    localparam int Y_LO    = -350;
    localparam int Y_HI    = 350;

    localparam int FX        = 32;    // position and speed fraction scale
    localparam int ANG_SCALE = 64;    // cordic angle fraction scale
    localparam int GAIN_INV  = 155;   // 0.607 with 8 fraction bits
    localparam int ATAN_DEG [8] = '{2880, 1700, 898, 456, 229, 115, 57, 29};

    logic   clk = 1'b0;
    logic   rst_n;
    logic   frame_req;
    logic   frame_ack;
    acc_t   car1_acc;
    acc_t   car2_acc;
    omega_t car1_omega;
    omega_t car2_omega;
    angle_t car1_angle;
    angle_t car2_angle;
    pix_x_t car1_x;
    pix_y_t car1_y;
    pix_x_t car2_x;
    pix_y_t car2_y;
    vel_t   car1_speed;
    vel_t   car2_speed;
    logic   prop_failed;
    logic   ack_seen;
    int     cycle_count = 0;
    int     seed = 32'ha05f_3352;

    // reference state per car with positions in 1/32 pixel
    int model_speed [2];
    int model_angle [2];
    int model_x [2];
    int model_y [2];

    assign prop_failed = i_game_control_top.u_game_control_properties.any_failed;

    game_control_top #(
        .CAR1_INIT_X (CAR1_X0),
        .CAR1_INIT_Y (CAR1_Y0),
        .CAR2_INIT_X (CAR2_X0),
        .CAR2_INIT_Y (CAR2_Y0),
        .X_MIN       (X_LO),
        .X_MAX       (X_HI),
        .Y_MIN       (Y_LO),
        .Y_MAX       (Y_HI)
    ) i_game_control_top (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_frame_req  (frame_req),
        .i_car1_acc   (car1_acc),
        .i_car2_acc   (car2_acc),
        .i_car1_omega (car1_omega),
        .i_car2_omega (car2_omega),
        .o_frame_ack  (frame_ack),
        .o_car1_angle (car1_angle),
        .o_car2_angle (car2_angle),
        .o_car1_x     (car1_x),
        .o_car1_y     (car1_y),
        .o_car2_x     (car2_x),
        .o_car2_y     (car2_y),
        .o_car1_v_m   (car1_speed),
        .o_car2_v_m   (car2_speed)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            stop_with_failure();
        end
    endtask

    // round half up to whole pixels
    function automatic int to_pixel(input int pos);
        return (pos >>> 5) + ((pos >>> 4) & 1);
    endfunction

    function automatic void reset_model();
        model_speed = '{0, 0};
        model_angle = '{0, 0};
        model_x[0] = CAR1_X0 * FX;
        model_y[0] = CAR1_Y0 * FX;
        model_x[1] = CAR2_X0 * FX;
        model_y[1] = CAR2_Y0 * FX;
    endfunction

    // one frame of one car
    function automatic void model_step(input int c, input int acc, input int omega);
        int i;
        int x;
        int y;
        int z;
        int dx;
        int dy;
        int speed;
        int ang;
        int px;
        int py;
        x = model_speed[c];   // velocity uses the state before this frame
        y = 0;
        z = model_angle[c] * ANG_SCALE;
        if (z > 90 * ANG_SCALE) begin
            z = z - 180 * ANG_SCALE;
            x = -x;
        end else if (z < -90 * ANG_SCALE) begin
            z = z + 180 * ANG_SCALE;
            x = -x;
        end
        for (i = 0; i < 8; i++) begin
            dx = y >>> i;
            dy = x >>> i;
            if (z >= 0) begin
                x = x - dx;
                y = y + dy;
                z = z - ATAN_DEG[i];
            end else begin
                x = x + dx;
                y = y - dy;
                z = z + ATAN_DEG[i];
            end
        end
        px = model_x[c] + ((x * GAIN_INV) >>> 8);
        py = model_y[c] + ((y * GAIN_INV) >>> 8);
        if (px <= X_LO * FX)      px = px + (X_HI - X_LO) * FX;
        else if (px >= X_HI * FX) px = px - (X_HI - X_LO) * FX;
        if (py <= Y_LO * FX)      py = py + (Y_HI - Y_LO) * FX;
        else if (py >= Y_HI * FX) py = py - (Y_HI - Y_LO) * FX;

        speed = (model_speed[c] >>> 1) + (acc << 4);
        if (speed < 0)           speed = 0;
        else if (speed > 7 * FX) speed = 7 * FX;

        ang = model_angle[c];
        if ((omega & 1) == 0) ang = ((omega & 2) != 0) ? ang + 1 : ang - 1;
        if (ang > 179)       ang = ang - 360;
        else if (ang < -180) ang = ang + 360;

        model_speed[c] = speed;
        model_angle[c] = ang;
        model_x[c]     = px;
        model_y[c]     = py;
    endfunction

    task automatic compare_outputs();
        assert (!car1_speed[VEL_WIDTH-1] && !car2_speed[VEL_WIDTH-1]) else begin
            $display("a car speed went negative");
            stop_with_failure();
        end
        check_value("o_car1_angle", int'(car1_angle), model_angle[0]);
        check_value("o_car1_x", int'(car1_x), to_pixel(model_x[0]));
        check_value("o_car1_y", int'(car1_y), to_pixel(model_y[0]));
        check_value("o_car1_v_m", int'(car1_speed), model_speed[0]);
        check_value("o_car2_angle", int'(car2_angle), model_angle[1]);
        check_value("o_car2_x", int'(car2_x), to_pixel(model_x[1]));
        check_value("o_car2_y", int'(car2_y), to_pixel(model_y[1]));
        check_value("o_car2_v_m", int'(car2_speed), model_speed[1]);
    endtask

    // one four-phase frame with req held for extra cycles after ack
    task automatic run_frame(input acc_t a1, input omega_t w1, input acc_t a2,
                             input omega_t w2, input int hold);
        @(posedge clk);
        car1_acc   <= a1;
        car1_omega <= w1;
        car2_acc   <= a2;
        car2_omega <= w2;
        frame_req  <= 1'b1;
        @(negedge clk);
        while (!frame_ack) @(negedge clk);
        repeat (hold) @(posedge clk);
        @(posedge clk);
        frame_req <= 1'b0;
        @(negedge clk);
        while (frame_ack) @(negedge clk);
    endtask

    // model steps once per rising frame ack
    always @(negedge clk) begin
        if (!rst_n) begin
            reset_model();
            compare_outputs();
            assert (!frame_ack) else begin
                $display("frame ack is high during reset");
                stop_with_failure();
            end
            ack_seen = 1'b0;
        end else begin
            assert (!(ack_seen && frame_req && !frame_ack)) else begin
                $display("frame ack dropped while the frame request was still high");
                stop_with_failure();
            end
            if (frame_ack && !ack_seen) begin
                model_step(0, int'(car1_acc), int'(car1_omega));
                model_step(1, int'(car2_acc), int'(car2_omega));
            end
            if (frame_ack || !frame_req) compare_outputs();   // outputs must be settled here
            assert (!prop_failed) else begin
                $display("a handshake property of the design failed");
                stop_with_failure();
            end
            ack_seen = frame_ack;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < CYCLE_LIMIT) else begin
            $display("timeout after %0d cycles, frames did not complete", cycle_count);
            stop_with_failure();
        end
    end

    initial begin
        int     n;
        acc_t   r_acc1;
        acc_t   r_acc2;
        omega_t r_om1;
        omega_t r_om2;
        int     r_hold;
        rst_n      = 1'b0;
        frame_req  = 1'b0;
        car1_acc   = '0;
        car2_acc   = '0;
        car1_omega = 2'b01;
        car2_omega = 2'b01;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (n = 0; n < LATE_FRAMES; n++) run_frame(3'd2, 2'b01, 3'd2, 2'b01, 4);
        for (n = 0; n < ACCEL_FRAMES; n++) run_frame(3'd7, 2'b01, 3'd7, 2'b11, 0);
        for (n = 0; n < DECAY_FRAMES; n++) run_frame(3'd0, 2'b01, 3'd0, 2'b01, 0);
        assert (car1_speed == '0 && car2_speed == '0) else begin
            $display("speed did not decay to zero without throttle");
            stop_with_failure();
        end

        // car 1 turns left through 179, car 2 right through -180
        for (n = 0; n < TURN_FRAMES; n++) run_frame(3'd3, 2'b10, 3'd3, 2'b00, 0);
        assert (int'(car1_angle) == -160 && int'(car2_angle) == 160) else begin
            $display("heading did not wrap around the half turn");
            stop_with_failure();
        end
        for (n = 0; n < CRUISE_FRAMES; n++) run_frame(3'd7, 2'b01, 3'd7, 2'b01, 0);

        for (n = 0; n < RANDOM_FRAMES; n++) begin
            r_acc1 = acc_t'($random(seed));
            r_om1  = omega_t'($random(seed));
            r_acc2 = acc_t'($random(seed));
            r_om2  = omega_t'($random(seed));
            r_hold = $random(seed) & 3;
            run_frame(r_acc1, r_om1, r_acc2, r_om2, r_hold);
        end

        repeat (2) @(posedge clk);
        if (!prop_failed) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/game_control_properties.sv
`timescale 1ns/10ps
`default_nettype none

module game_control_properties (
    input wire       i_clk,
    input wire       i_rst_n,
    input wire       i_frame_req,
    input wire       i_frame_ack,
    input wire       i_rot_req,    // shared rotator bus
    input wire       i_rot_ack,
    input wire       i_car1_req,
    input wire       i_car1_ack,
    input wire       i_car2_req,
    input wire       i_car2_ack,
    input wire [1:0] i_grant
);

    // sticky failure flags
    logic frame_ack_bad = 1'b0;
    logic frame_req_bad = 1'b0;
    logic rot_ack_bad   = 1'b0;
    logic rot_req_bad   = 1'b0;
    logic car1_ack_bad  = 1'b0;
    logic car2_ack_bad  = 1'b0;
    logic grant_bad     = 1'b0;
    logic any_failed;

    assign any_failed = frame_ack_bad | frame_req_bad | rot_ack_bad | rot_req_bad
                      | car1_ack_bad | car2_ack_bad | grant_bad;

    frame_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_frame_ack) |-> i_frame_req)
    else begin
        $error("frame ack rose without a frame request");
        frame_ack_bad = 1'b1;
    end

    frame_req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_frame_req && !i_frame_ack |=> i_frame_req)
    else begin
        $error("frame request dropped before its ack");
        frame_req_bad = 1'b1;
    end

    rot_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_rot_ack) |-> i_rot_req)
    else begin
        $error("rotator ack rose without a request");
        rot_ack_bad = 1'b1;
    end

    rot_req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rot_req && !i_rot_ack |=> i_rot_req)
    else begin
        $error("rotator request dropped before its ack");
        rot_req_bad = 1'b1;
    end

    car1_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_car1_ack) |-> i_car1_req)
    else begin
        $error("car 1 got a rotation ack it did not request");
        car1_ack_bad = 1'b1;
    end

    car2_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_car2_ack) |-> i_car2_req)
    else begin
        $error("car 2 got a rotation ack it did not request");
        car2_ack_bad = 1'b1;
    end

    one_grant: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rot_ack |-> (i_car1_ack ^ i_car2_ack) && $stable(i_grant))
    else begin
        $error("rotator result did not go to exactly one granted car");
        grant_bad = 1'b1;
    end

endmodule

bind game_control_top game_control_properties u_game_control_properties (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_frame_req (i_frame_req),
    .i_frame_ack (o_frame_ack),
    .i_rot_req   (rot_bus.req),
    .i_rot_ack   (rot_bus.ack),
    .i_car1_req  (car1_rot.req),
    .i_car1_ack  (car1_rot.ack),
    .i_car2_req  (car2_rot.req),
    .i_car2_ack  (car2_rot.ack),
    .i_grant     (u_rotate_arbiter.grant_q)
);

`default_nettype wire

// File: src/game_control_top.sv
`timescale 1ns/10ps
`default_nettype none

module game_control_top import game_pkg::*; #(
    parameter int CAR1_INIT_X = -750,
    parameter int CAR1_INIT_Y = 300,
    parameter int CAR2_INIT_X = 750,
    parameter int CAR2_INIT_Y = -300,
    parameter int X_MIN       = -750,
    parameter int X_MAX       = 750,
    parameter int Y_MIN       = -350,
    parameter int Y_MAX       = 350
) (
    input wire         i_clk,
    input wire         i_rst_n,
    input wire         i_frame_req,
    input wire acc_t   i_car1_acc,
    input wire acc_t   i_car2_acc,
    input wire omega_t i_car1_omega,
    input wire omega_t i_car2_omega,
    output logic       o_frame_ack,
    output angle_t     o_car1_angle,
    output angle_t     o_car2_angle,
    output pix_x_t     o_car1_x,
    output pix_y_t     o_car1_y,
    output pix_x_t     o_car2_x,
    output pix_y_t     o_car2_y,
    output vel_t       o_car1_v_m,
    output vel_t       o_car2_v_m
);

    logic [1:0] step_req;   // index 0 car 1
    logic [1:0] step_ack;

    rotate_if car1_rot ();
    rotate_if car2_rot ();
    rotate_if rot_bus ();    // arbiter to the shared rotator

    frame_sequencer u_frame_sequencer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_frame_req (i_frame_req),
        .o_frame_ack (o_frame_ack),
        .o_step_req  (step_req),
        .i_step_ack  (step_ack)
    );

    car_dynamics #(
        .INIT_X (CAR1_INIT_X),
        .INIT_Y (CAR1_INIT_Y),
        .X_MIN  (X_MIN),
        .X_MAX  (X_MAX),
        .Y_MIN  (Y_MIN),
        .Y_MAX  (Y_MAX)
    ) u_car1 (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_step_req (step_req[0]),
        .o_step_ack (step_ack[0]),
        .i_acc      (i_car1_acc),
        .i_omega    (i_car1_omega),
        .rot        (car1_rot),
        .o_angle    (o_car1_angle),
        .o_x        (o_car1_x),
        .o_y        (o_car1_y),
        .o_speed    (o_car1_v_m)
    );

    car_dynamics #(
        .INIT_X (CAR2_INIT_X),
        .INIT_Y (CAR2_INIT_Y),
        .X_MIN  (X_MIN),
        .X_MAX  (X_MAX),
        .Y_MIN  (Y_MIN),
        .Y_MAX  (Y_MAX)
    ) u_car2 (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_step_req (step_req[1]),
        .o_step_ack (step_ack[1]),
        .i_acc      (i_car2_acc),
        .i_omega    (i_car2_omega),
        .rot        (car2_rot),
        .o_angle    (o_car2_angle),
        .o_x        (o_car2_x),
        .o_y        (o_car2_y),
        .o_speed    (o_car2_v_m)
    );

    rotate_arbiter u_rotate_arbiter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .car1    (car1_rot),
        .car2    (car2_rot),
        .rot     (rot_bus)
    );

    rotate_xy u_rotate_xy (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .rot     (rot_bus)
    );

endmodule

`default_nettype wire

// File: src/frame_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_sequencer (
    input wire         i_clk,
    input wire         i_rst_n,
    input wire         i_frame_req,
    output logic       o_frame_ack,
    output logic [1:0] o_step_req,   // bit 0 car 1, bit 1 car 2
    input wire   [1:0] i_step_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STEP,
        ST_ACK
    } seq_state_t;

    seq_state_t state_q;
    logic [1:0] step_done_q;   // car has acked this frame

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q     <= ST_IDLE;
            step_done_q <= 2'b00;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    step_done_q <= 2'b00;
                    if (i_frame_req) state_q <= ST_STEP;
                end
                ST_STEP: begin
                    step_done_q <= step_done_q | i_step_ack;
                    if (&step_done_q) state_q <= ST_ACK;
                end
                default: begin
                    // both step links and the frame link back to zero
                    if (!i_frame_req && i_step_ack == 2'b00) state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // each car's req drops as soon as its ack is latched
    assign o_step_req  = (state_q == ST_STEP) ? ~step_done_q : 2'b00;
    assign o_frame_ack = (state_q == ST_ACK);

endmodule

`default_nettype wire

// File: src/car_dynamics.sv
`timescale 1ns/10ps
`default_nettype none

module car_dynamics import game_pkg::*; #(
    parameter int INIT_X = 0,
    parameter int INIT_Y = 0,
    parameter int X_MIN  = -750,
    parameter int X_MAX  = 750,
    parameter int Y_MIN  = -350,
    parameter int Y_MAX  = 350
) (
    input wire          i_clk,
    input wire          i_rst_n,
    input wire          i_step_req,
    output logic        o_step_ack,
    input wire acc_t    i_acc,
    input wire omega_t  i_omega,
    rotate_if.requester rot,
    output angle_t      o_angle,
    output pix_x_t      o_x,
    output pix_y_t      o_y,
    output vel_t        o_speed
);

    localparam int FX = 2 ** VEL_FRAC_WIDTH;
    localparam int ACC_SHIFT = VEL_FRAC_WIDTH - FRICTION_SHIFT;

    localparam logic signed [VEL_WIDTH:0] SPEED_MAX = (VEL_WIDTH+1)'(VELOCITY_MAX * FX);
    localparam logic signed [ANG_WIDTH:0] ANG_ONE   = 1;
    localparam logic signed [ANG_WIDTH:0] ANG_HI    = 179;
    localparam logic signed [ANG_WIDTH:0] ANG_LO    = -180;
    localparam logic signed [ANG_WIDTH:0] ANG_TURN  = 360;

    localparam logic signed [POS_X_WIDTH:0] X_LO_FX   = (POS_X_WIDTH+1)'(X_MIN * FX);
    localparam logic signed [POS_X_WIDTH:0] X_HI_FX   = (POS_X_WIDTH+1)'(X_MAX * FX);
    localparam logic signed [POS_X_WIDTH:0] X_SPAN_FX = (POS_X_WIDTH+1)'((X_MAX - X_MIN) * FX);
    localparam logic signed [POS_Y_WIDTH:0] Y_LO_FX   = (POS_Y_WIDTH+1)'(Y_MIN * FX);
    localparam logic signed [POS_Y_WIDTH:0] Y_HI_FX   = (POS_Y_WIDTH+1)'(Y_MAX * FX);
    localparam logic signed [POS_Y_WIDTH:0] Y_SPAN_FX = (POS_Y_WIDTH+1)'((Y_MAX - Y_MIN) * FX);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROTATE,
        ST_RELEASE,
        ST_ACK
    } car_state_t;

    car_state_t state_q;
    logic       rot_req_q;
    vel_t       speed_q;
    angle_t     angle_q;
    pos_x_t     pos_x_q;
    pos_y_t     pos_y_q;

    logic signed [VEL_WIDTH:0]   speed_half;
    logic signed [VEL_WIDTH:0]   acc_term;
    logic signed [VEL_WIDTH:0]   speed_sum;
    logic signed [ANG_WIDTH:0]   ang_sum;
    logic signed [POS_X_WIDTH:0] x_sum;
    logic signed [POS_Y_WIDTH:0] y_sum;

    // rotation operands come straight from the pre-step state
    assign rot.req   = rot_req_q;
    assign rot.mag   = speed_q;
    assign rot.angle = angle_q;

    always_comb begin
        // friction, then throttle, then clamp to 0..VELOCITY_MAX
        speed_half = (VEL_WIDTH+1)'(speed_q >>> FRICTION_SHIFT);
        acc_term   = (VEL_WIDTH+1)'(i_acc) << ACC_SHIFT;
        speed_sum  = speed_half + acc_term;
        if (speed_sum < 0)              speed_sum = '0;
        else if (speed_sum > SPEED_MAX) speed_sum = SPEED_MAX;

        ang_sum = (ANG_WIDTH+1)'(angle_q);
        if (!i_omega[0]) begin
            if (i_omega[1]) ang_sum = ang_sum + ANG_ONE;
            else            ang_sum = ang_sum - ANG_ONE;
        end
        if (ang_sum > ANG_HI)      ang_sum = ang_sum - ANG_TURN;
        else if (ang_sum < ANG_LO) ang_sum = ang_sum + ANG_TURN;

        // move by the rotated velocity, wrap at the map edges
        x_sum = (POS_X_WIDTH+1)'(pos_x_q) + (POS_X_WIDTH+1)'(rot.out_x);
        y_sum = (POS_Y_WIDTH+1)'(pos_y_q) + (POS_Y_WIDTH+1)'(rot.out_y);
        if (x_sum <= X_LO_FX)      x_sum = x_sum + X_SPAN_FX;
        else if (x_sum >= X_HI_FX) x_sum = x_sum - X_SPAN_FX;
        if (y_sum <= Y_LO_FX)      y_sum = y_sum + Y_SPAN_FX;
        else if (y_sum >= Y_HI_FX) y_sum = y_sum - Y_SPAN_FX;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q    <= ST_IDLE;
            rot_req_q  <= 1'b0;
            o_step_ack <= 1'b0;
            speed_q    <= '0;
            angle_q    <= '0;
            pos_x_q    <= pos_x_t'(INIT_X * FX);
            pos_y_q    <= pos_y_t'(INIT_Y * FX);
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_step_req) begin
                        rot_req_q <= 1'b1;
                        state_q   <= ST_ROTATE;
                    end
                end
                ST_ROTATE: begin
                    if (rot.ack) begin   // whole step lands in this cycle
                        speed_q    <= vel_t'(speed_sum);
                        angle_q    <= angle_t'(ang_sum);
                        pos_x_q    <= pos_x_t'(x_sum);
                        pos_y_q    <= pos_y_t'(y_sum);
                        rot_req_q  <= 1'b0;
                        o_step_ack <= 1'b1;
                        state_q    <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (!rot.ack) state_q <= ST_ACK;
                end
                default: begin
                    if (!i_step_req) begin
                        o_step_ack <= 1'b0;
                        state_q    <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    assign o_angle = angle_q;
    assign o_speed = speed_q;
    assign o_x = pix_x_t'(pos_x_q >>> VEL_FRAC_WIDTH) + pix_x_t'(pos_x_q[VEL_FRAC_WIDTH-1]);
    assign o_y = pix_y_t'(pos_y_q >>> VEL_FRAC_WIDTH) + pix_y_t'(pos_y_q[VEL_FRAC_WIDTH-1]);

endmodule

`default_nettype wire

// File: src/rotate_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module rotate_arbiter import game_pkg::*; (
    input wire          i_clk,
    input wire          i_rst_n,
    rotate_if.rotator   car1,
    rotate_if.rotator   car2,
    rotate_if.requester rot
);

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_CAR1,
        GRANT_CAR2
    } grant_t;

    grant_t grant_q;
    logic   ack_seen_q;   // forwarded ack went high in this grant

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            grant_q    <= GRANT_NONE;
            ack_seen_q <= 1'b0;
        end else if (grant_q == GRANT_NONE) begin
            ack_seen_q <= 1'b0;
            if (car1.req)      grant_q <= GRANT_CAR1;   // car 1 wins ties
            else if (car2.req) grant_q <= GRANT_CAR2;
        end else if (rot.ack) begin
            ack_seen_q <= 1'b1;
        end else if (ack_seen_q) begin
            // ack back low, transaction closed
            grant_q    <= GRANT_NONE;
            ack_seen_q <= 1'b0;
        end
    end

    always_comb begin
        rot.req   = 1'b0;
        rot.mag   = car1.mag;
        rot.angle = car1.angle;
        if (grant_q == GRANT_CAR1) begin
            rot.req = car1.req;
        end else if (grant_q == GRANT_CAR2) begin
            rot.req   = car2.req;
            rot.mag   = car2.mag;
            rot.angle = car2.angle;
        end
    end

    assign car1.ack   = (grant_q == GRANT_CAR1) && rot.ack;
    assign car2.ack   = (grant_q == GRANT_CAR2) && rot.ack;
    assign car1.out_x = (grant_q == GRANT_CAR1) ? rot.out_x : '0;
    assign car1.out_y = (grant_q == GRANT_CAR1) ? rot.out_y : '0;
    assign car2.out_x = (grant_q == GRANT_CAR2) ? rot.out_x : '0;
    assign car2.out_y = (grant_q == GRANT_CAR2) ? rot.out_y : '0;

endmodule

`default_nettype wire

// File: rotate/rotate_xy.sv
`timescale 1ns/10ps
`default_nettype none

module rotate_xy import game_pkg::*; (
    input wire        i_clk,
    input wire        i_rst_n,
    rotate_if.rotator rot
);

    localparam int XY_WIDTH  = VEL_WIDTH + 2;   // headroom for the cordic gain
    localparam int Z_WIDTH   = ANG_WIDTH + CORDIC_ANG_FRAC + 1;
    localparam int CNT_WIDTH = $clog2(CORDIC_ITER);
    localparam int PROD_WIDTH = XY_WIDTH + CORDIC_GAIN_FRAC + 1;

    localparam logic signed [Z_WIDTH-1:0] QUARTER_TURN = Z_WIDTH'(90 << CORDIC_ANG_FRAC);
    localparam logic signed [Z_WIDTH-1:0] HALF_TURN    = Z_WIDTH'(180 << CORDIC_ANG_FRAC);
    localparam logic signed [CORDIC_GAIN_FRAC:0] GAIN_S = {1'b0, CORDIC_GAIN_INV};

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_SCALE,
        ST_DONE
    } rot_state_t;

    rot_state_t                  state_q;
    logic [CNT_WIDTH-1:0]        iter_q;
    logic signed [XY_WIDTH-1:0]  x_q;
    logic signed [XY_WIDTH-1:0]  y_q;
    logic signed [Z_WIDTH-1:0]   z_q;   // residual angle still to rotate
    logic signed [Z_WIDTH-1:0]   ang_fx;
    logic signed [XY_WIDTH-1:0]  mag_ext;
    logic signed [XY_WIDTH-1:0]  x_shift;
    logic signed [XY_WIDTH-1:0]  y_shift;
    logic signed [Z_WIDTH-1:0]   atan_step;
    logic signed [PROD_WIDTH-1:0] prod_x;
    logic signed [PROD_WIDTH-1:0] prod_y;

    assign ang_fx    = {rot.angle[ANG_WIDTH-1], rot.angle, {CORDIC_ANG_FRAC{1'b0}}};
    assign mag_ext   = XY_WIDTH'(rot.mag);
    assign x_shift   = y_q >>> iter_q;
    assign y_shift   = x_q >>> iter_q;
    assign atan_step = Z_WIDTH'(ATAN_TABLE[iter_q]);
    assign prod_x    = x_q * GAIN_S;
    assign prod_y    = y_q * GAIN_S;

    assign rot.ack = (state_q == ST_DONE);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            iter_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    iter_q <= '0;
                    if (rot.req) state_q <= ST_RUN;
                end
                ST_RUN: begin
                    iter_q <= iter_q + 1'b1;
                    if (iter_q == CNT_WIDTH'(CORDIC_ITER - 1)) state_q <= ST_SCALE;
                end
                ST_SCALE: state_q <= ST_DONE;
                default: begin
                    if (!rot.req) state_q <= ST_IDLE;   // requester closed the handshake
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge i_clk) begin
        if (state_q == ST_IDLE && rot.req) begin
            // fold into -90..90, the vector flips instead
            y_q <= '0;
            if (ang_fx > QUARTER_TURN) begin
                z_q <= ang_fx - HALF_TURN;
                x_q <= -mag_ext;
            end else if (ang_fx < -QUARTER_TURN) begin
                z_q <= ang_fx + HALF_TURN;
                x_q <= -mag_ext;
            end else begin
                z_q <= ang_fx;
                x_q <= mag_ext;
            end
        end else if (state_q == ST_RUN) begin
            if (z_q >= 0) begin   // rotate counter-clockwise
                x_q <= x_q - x_shift;
                y_q <= y_q + y_shift;
                z_q <= z_q - atan_step;
            end else begin
                x_q <= x_q + x_shift;
                y_q <= y_q - y_shift;
                z_q <= z_q + atan_step;
            end
        end

        if (state_q == ST_SCALE) begin
            rot.out_x <= vel_t'(prod_x >>> CORDIC_GAIN_FRAC);   // truncate toward -inf
            rot.out_y <= vel_t'(prod_y >>> CORDIC_GAIN_FRAC);
        end
    end

endmodule

`default_nettype wire

// File: common/rotate_if.sv
`timescale 1ns/10ps
`default_nettype none

// one four-phase rotation transaction: speed and heading in, vector out
interface rotate_if import game_pkg::*; ();

    logic   req;
    logic   ack;
    vel_t   mag;     // speed to rotate
    angle_t angle;   // heading in degrees
    vel_t   out_x;   // valid while ack high
    vel_t   out_y;

    modport requester (
        output req, mag, angle,
        input  ack, out_x, out_y
    );

    modport rotator (
        input  req, mag, angle,
        output ack, out_x, out_y
    );

endinterface

`default_nettype wire

// File: common/game_pkg.sv
`default_nettype none

package game_pkg;

    // heading in whole degrees, -180 to 179
    parameter int ANG_WIDTH = 9;

    // speed and velocity fixed point
    parameter int VEL_INT_WIDTH  = 3;
    parameter int VEL_FRAC_WIDTH = 5;
    // sign bit on top of the integer part so that a full 7.0 still fits
    parameter int VEL_WIDTH      = VEL_INT_WIDTH + VEL_FRAC_WIDTH + 1;

    // map size in whole pixels
    parameter int MAP_H_WIDTH = 11;
    parameter int MAP_V_WIDTH = 10;
    parameter int POS_X_WIDTH = MAP_H_WIDTH + VEL_FRAC_WIDTH;   // 16
    parameter int POS_Y_WIDTH = MAP_V_WIDTH + VEL_FRAC_WIDTH;   // 15

    typedef logic signed [ANG_WIDTH-1:0]   angle_t;
    typedef logic signed [VEL_WIDTH-1:0]   vel_t;
    typedef logic signed [POS_X_WIDTH-1:0] pos_x_t;
    typedef logic signed [POS_Y_WIDTH-1:0] pos_y_t;
    typedef logic signed [MAP_H_WIDTH-1:0] pix_x_t;
    typedef logic signed [MAP_V_WIDTH-1:0] pix_y_t;
    typedef logic [2:0]                    acc_t;     // 0 to 7
    typedef logic [1:0]                    omega_t;   // bit 0 hold, else bit 1 picks direction

    // physics
    parameter int FRICTION_SHIFT = 1;
    parameter int VELOCITY_MAX   = 7;   // whole units

    // cordic rotator
    parameter int CORDIC_ITER      = 8;
    parameter int CORDIC_ANG_FRAC  = 6;
    parameter int CORDIC_GAIN_FRAC = 8;
    parameter logic [CORDIC_GAIN_FRAC-1:0] CORDIC_GAIN_INV = 8'd155;   // 0.607

    // atan(2^-i) in degrees, 6 fraction bits
    parameter int ATAN_TABLE [CORDIC_ITER] = '{
        2880, 1700, 898, 456, 229, 115, 57, 29
    };

endpackage

`default_nettype wire
